/* common/synth_cfg.svh */
`ifndef SYNTH_CFG_SVH
`define SYNTH_CFG_SVH

// voice bank.
`define SYNTH_NUM_VOICES  4
`define SYNTH_SAMPLE_BITS 16
`define SYNTH_ADDR_BITS   8

// phase accumulator, the msb marks half scale.
`define SYNTH_ACC_BITS    24

// ----------------------------------------------------------
// frame dividers, CLK cycles per half period.
// ----------------------------------------------------------
`define SYNTH_SCLK_HALF   4
`define SYNTH_LR_HALF     256

`endif

/* common/synth_pkg.sv */
`default_nettype none

`include "synth_cfg.svh"

package synth_pkg;

	typedef logic signed [`SYNTH_SAMPLE_BITS-1:0] sample_t;
	typedef logic [`SYNTH_SAMPLE_BITS-1:0] freq_t;

	// upper bits pick the voice, the two low bits pick the register.
	typedef logic [`SYNTH_ADDR_BITS-1:0] addr_t;

	typedef enum logic [1:0] {
		REG_FREQ = 2'd0,
		REG_AMPL = 2'd1
	} reg_sel_e;

endpackage

`default_nettype wire

/* logic/voice_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module voice_regs (
	input  wire                           CLK,
	input  wire                           rst_n,
	input  wire synth_pkg::addr_t         address,
	input  wire synth_pkg::sample_t       wdata,
	input  wire                           wr,
	output synth_pkg::sample_t            rdata,
	output synth_pkg::freq_t              freq [`SYNTH_NUM_VOICES],
	output synth_pkg::sample_t            ampl [`SYNTH_NUM_VOICES],
	output logic [`SYNTH_NUM_VOICES-1:0]  ampl_wr
);
	import synth_pkg::*;

	localparam int VIDX_BITS = $clog2(`SYNTH_NUM_VOICES);

	logic [`SYNTH_ADDR_BITS-3:0] voice_sel;
	logic [VIDX_BITS-1:0]        vidx;
	logic                        voice_ok;
	reg_sel_e                    reg_sel;

	assign voice_sel = address[`SYNTH_ADDR_BITS-1:2];
	assign vidx      = voice_sel[VIDX_BITS-1:0];
	assign voice_ok  = (voice_sel < `SYNTH_NUM_VOICES); // voices past the bank are ignored.
	assign reg_sel   = reg_sel_e'(address[1:0]);

	// ----------------------------------------------------------
	// register writes
	// ----------------------------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SYNTH_NUM_VOICES; i++) begin
				freq[i] <= '0;
				ampl[i] <= '0;
			end
		end else if (wr && voice_ok) begin
			case (reg_sel)
				REG_FREQ: freq[vidx] <= freq_t'(wdata);
				REG_AMPL: ampl[vidx] <= wdata;
				default: ;
			endcase
		end
	end

	// the voice restarts in phase whenever its amplitude is written.
	always_comb begin
		ampl_wr = '0;
		if (wr && voice_ok && reg_sel == REG_AMPL)
			ampl_wr[vidx] = 1'b1;
	end

	always_comb begin
		rdata = '0; // unused offsets read as zero.
		if (voice_ok) begin
			case (reg_sel)
				REG_FREQ: rdata = sample_t'(freq[vidx]);
				REG_AMPL: rdata = ampl[vidx];
				default: ;
			endcase
		end
	end

	a_one_restart: assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(ampl_wr));

endmodule

`default_nettype wire

/* voice/square_voice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module square_voice (
	input  wire                     CLK,
	input  wire                     rst_n,
	input  wire synth_pkg::freq_t   freq,
	input  wire synth_pkg::sample_t ampl,
	input  wire                     restart,
	output synth_pkg::sample_t      sample
);

	localparam int ACC_BITS = `SYNTH_ACC_BITS;

	// half scale plus the largest increment bounds the accumulator.
	localparam logic [ACC_BITS-1:0] ACC_LIMIT =
		ACC_BITS'((1 << (ACC_BITS - 1)) + (1 << `SYNTH_SAMPLE_BITS) - 1);

	logic [ACC_BITS-1:0] acc;
	logic                pol;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			acc    <= '0;
			pol    <= 1'b0;
			sample <= '0;
		end else begin
			if (restart) begin
				acc <= '0;
				pol <= 1'b0;
			end else if (acc[ACC_BITS-1]) begin // past half scale.
				acc <= '0;
				pol <= ~pol;
			end else begin
				acc <= acc + ACC_BITS'(freq);
			end
			sample <= pol ? -ampl : ampl;
		end
	end

	a_acc_bound: assert property (@(posedge CLK) disable iff (!rst_n) acc <= ACC_LIMIT);

endmodule

`default_nettype wire

/* logic/voice_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module voice_mixer (
	input  wire                     CLK,
	input  wire                     rst_n,
	input  wire synth_pkg::sample_t voice_samples [`SYNTH_NUM_VOICES],
	output synth_pkg::sample_t      mix
);
	import synth_pkg::*;

	// one guard bit per doubling plus one spare keeps the sum exact.
	localparam int SUM_BITS = `SYNTH_SAMPLE_BITS + $clog2(`SYNTH_NUM_VOICES) + 1;

	localparam logic signed [SUM_BITS-1:0] SUM_MAX = (2 ** (`SYNTH_SAMPLE_BITS - 1)) - 1;
	localparam logic signed [SUM_BITS-1:0] SUM_MIN = -(2 ** (`SYNTH_SAMPLE_BITS - 1));

	logic signed [SUM_BITS-1:0] sum;
	sample_t                    sat;

	always_comb begin
		sum = '0;
		for (int i = 0; i < `SYNTH_NUM_VOICES; i++)
			sum = sum + voice_samples[i]; // sign extended to SUM_BITS.
	end

	// ----------------------------------------------------------
	// clamp to the sample range
	// ----------------------------------------------------------
	always_comb begin
		if (sum > SUM_MAX)
			sat = sample_t'(SUM_MAX);
		else if (sum < SUM_MIN)
			sat = sample_t'(SUM_MIN);
		else
			sat = sample_t'(sum);
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			mix <= '0;
		else
			mix <= sat;
	end

endmodule

`default_nettype wire

/* i2s/i2s_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module i2s_clock_gen (
	input  wire  CLK,
	input  wire  rst_n,
	output logic sclk,
	output logic lrclk,
	output logic load,
	output logic shift
);

	localparam int SCLK_CNT_BITS = $clog2(`SYNTH_SCLK_HALF);
	localparam int LR_CNT_BITS   = $clog2(`SYNTH_LR_HALF);

	localparam logic [SCLK_CNT_BITS-1:0] SCLK_LAST = SCLK_CNT_BITS'(`SYNTH_SCLK_HALF - 1);
	localparam logic [LR_CNT_BITS-1:0]   LR_LAST   = LR_CNT_BITS'(`SYNTH_LR_HALF - 1);

	logic [SCLK_CNT_BITS-1:0] sclk_cnt;
	logic [LR_CNT_BITS-1:0]   lr_cnt;
	logic                     sclk_next;
	logic                     lrclk_next;

	assign sclk_next  = (sclk_cnt == SCLK_LAST) ? ~sclk : sclk;
	assign lrclk_next = (lr_cnt == LR_LAST) ? ~lrclk : lrclk;

	// strobes mark the cycle before the matching clock edge.
	assign load  = (lrclk_next != lrclk);
	assign shift = sclk && !sclk_next && !load;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sclk_cnt <= '0;
			lr_cnt   <= '0;
			sclk     <= 1'b0;
			lrclk    <= 1'b0;
		end else begin
			sclk_cnt <= (sclk_cnt == SCLK_LAST) ? '0 : sclk_cnt + 1'b1;
			lr_cnt   <= (lr_cnt == LR_LAST) ? '0 : lr_cnt + 1'b1;
			sclk     <= sclk_next;
			lrclk    <= lrclk_next;
		end
	end

	a_lr_on_sclk_fall: assert property (@(posedge CLK) disable iff (!rst_n)
		$changed(lrclk) |-> $fell(sclk));

endmodule

`default_nettype wire

/* i2s/i2s_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module i2s_serializer (
	input  wire                     CLK,
	input  wire                     rst_n,
	input  wire synth_pkg::sample_t mix,
	input  wire                     load,
	input  wire                     shift,
	output wire                     sdata
);

	// one slot is half a word-clock period of sclk cycles.
	localparam int SLOT_BITS = `SYNTH_LR_HALF / (2 * `SYNTH_SCLK_HALF);
	localparam int TAIL_BITS = SLOT_BITS - `SYNTH_SAMPLE_BITS - 1;

	logic [SLOT_BITS-1:0] slot;

	// ----------------------------------------------------------
	// slot shift register, pad bit first
	// ----------------------------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			slot <= '0;
		else if (load)
			slot <= {1'b0, mix, {TAIL_BITS{1'b0}}}; // the same mix goes to both channels.
		else if (shift)
			slot <= {slot[SLOT_BITS-2:0], 1'b0};
	end

	assign sdata = slot[SLOT_BITS-1];

	a_load_xor_shift: assert property (@(posedge CLK) disable iff (!rst_n) !(load && shift));

endmodule

`default_nettype wire

/* logic/audio_synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module audio_synth_top (
	input  wire                     CLK,
	input  wire                     rst_n,
	input  wire synth_pkg::addr_t   address,
	input  wire synth_pkg::sample_t wdata,
	input  wire                     wr,
	output wire synth_pkg::sample_t rdata,
	output wire                     mclk,
	output wire                     sclk,
	output wire                     lrclk,
	output wire                     sdata
);
	import synth_pkg::*;

	freq_t                       freq          [`SYNTH_NUM_VOICES];
	sample_t                     ampl          [`SYNTH_NUM_VOICES];
	sample_t                     voice_samples [`SYNTH_NUM_VOICES];
	logic [`SYNTH_NUM_VOICES-1:0] ampl_wr;
	sample_t                     mix;
	logic                        load;
	logic                        shift;

	assign mclk = CLK; // the codec runs its master clock straight off CLK.

	voice_regs u_regs (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.address (address),
		.wdata   (wdata),
		.wr      (wr),
		.rdata   (rdata),
		.freq    (freq),
		.ampl    (ampl),
		.ampl_wr (ampl_wr)
	);

	for (genvar v = 0; v < `SYNTH_NUM_VOICES; v++) begin : g_voice
		square_voice u_voice (
			.CLK     (CLK),
			.rst_n   (rst_n),
			.freq    (freq[v]),
			.ampl    (ampl[v]),
			.restart (ampl_wr[v]),
			.sample  (voice_samples[v])
		);
	end

	voice_mixer u_mixer (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.voice_samples (voice_samples),
		.mix           (mix)
	);

	i2s_clock_gen u_clk_gen (
		.CLK   (CLK),
		.rst_n (rst_n),
		.sclk  (sclk),
		.lrclk (lrclk),
		.load  (load),
		.shift (shift)
	);

	i2s_serializer u_ser (
		.CLK   (CLK),
		.rst_n (rst_n),
		.mix   (mix),
		.load  (load),
		.shift (shift),
		.sdata (sdata)
	);

endmodule

`default_nettype wire

/* sim/tb_audio_synth.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module tb_audio_synth;

	localparam int NUM_FIXED   = 8;
	localparam int NUM_ENTRIES = NUM_FIXED + 4;
	localparam int EXTRA_STEPS = 6; // reset, readback, bad writes, timing and square wave.
	localparam longint WATCH_NS = ((NUM_ENTRIES + EXTRA_STEPS) * 4 * 512 + 64) * 100;

	logic        CLK = 1'b0;
	logic        rst_n;
	logic [7:0]  address;
	logic [15:0] wdata;
	logic        wr;
	wire  [15:0] rdata;
	wire         mclk;
	wire         sclk;
	wire         lrclk;
	wire         sdata;

	int          errors = 0;
	int          seed = 32'ha914;

	// stimulus table, all at frequency zero.
	int          tbl_voice [NUM_ENTRIES];
	logic [15:0] tbl_ampl  [NUM_ENTRIES];
	logic [15:0] tbl_exp   [NUM_ENTRIES];
	bit          tbl_rand  [NUM_ENTRIES];
	logic [15:0] ampl_model [`SYNTH_NUM_VOICES];

	audio_synth_top u_dut (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.address (address),
		.wdata   (wdata),
		.wr      (wr),
		.rdata   (rdata),
		.mclk    (mclk),
		.sclk    (sclk),
		.lrclk   (lrclk),
		.sdata   (sdata)
	);

	always #50 CLK = ~CLK;

	initial begin
		#(WATCH_NS);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [15:0] d);
		@(posedge CLK);
		address <= a;
		wdata   <= d;
		wr      <= 1'b1;
		@(posedge CLK);
		wr      <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] a, output logic [15:0] d);
		@(posedge CLK);
		address <= a;
		@(negedge CLK);
		d = rdata;
	endtask

	// ------------------------------------------------------------
	// I2S receiver, pad bit then 16 bits MSB first
	// ------------------------------------------------------------
	task automatic receive_slot(output logic [15:0] w);
		@(posedge sclk); // pad bit.
		for (int i = 0; i < 16; i++) begin
			@(posedge sclk);
			w = {w[14:0], sdata};
		end
	endtask

	task automatic capture_frame(output logic [15:0] left, output logic [15:0] right);
		@(negedge lrclk);
		receive_slot(left);
		@(posedge lrclk);
		receive_slot(right);
	endtask

	task automatic check_frame(input logic [15:0] exp);
		logic [15:0] left;
		logic [15:0] right;
		capture_frame(left, right);
		check_val("sdata left", exp, left);
		check_val("sdata right", exp, right);
	endtask

	// counts CLK cycles of one full half period of sclk (sel 0) or lrclk.
	task automatic measure_half(input int sel, output int n);
		logic prev;
		prev = sel ? lrclk : sclk;
		do @(negedge CLK); while ((sel ? lrclk : sclk) == prev);
		prev = sel ? lrclk : sclk;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while ((sel ? lrclk : sclk) == prev);
	endtask

	function automatic logic [15:0] saturate_sum();
		int s;
		s = 0;
		for (int v = 0; v < `SYNTH_NUM_VOICES; v++)
			s += $signed(ampl_model[v]);
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return s[15:0];
	endfunction

	task automatic build_table();
		tbl_voice = '{0, 1, 2, 3, 1, 0, 3, 1, 0, 1, 2, 3};
		tbl_ampl  = '{16'h1000, 16'h0234, 16'hfb00, 16'h7000, 16'h7fff, 16'h8000,
			16'h8000, 16'h8000, 0, 0, 0, 0};
		tbl_exp   = '{16'h1000, 16'h1234, 16'h0d34, 16'h7d34, 16'h7fff, 16'h6aff,
			16'h8000, 16'h8000, 0, 0, 0, 0};
		for (int i = 0; i < NUM_ENTRIES; i++)
			tbl_rand[i] = (i >= NUM_FIXED);
	endtask

	initial begin
		logic [15:0] d;
		logic [15:0] left;
		logic [15:0] right;
		logic [15:0] last_mix;
		int n;
		bit saw_pos;
		bit saw_neg;

		rst_n   = 1'b0;
		address = '0;
		wdata   = '0;
		wr      = 1'b0;
		build_table();
		repeat (15) @(posedge CLK);
		@(negedge CLK);
		if (sclk !== 1'b0 || lrclk !== 1'b0 || sdata !== 1'b0) begin
			errors++;
			$display("I2S outputs are not low during reset");
		end
		@(posedge CLK);
		rst_n <= 1'b1;

		// registers clear and silent output after reset.
		for (int v = 0; v < `SYNTH_NUM_VOICES; v++) begin
			ampl_model[v] = '0;
			for (int r = 0; r < 2; r++) begin
				read_reg(8'((v << 2) | r), d);
				check_val("rdata", 16'h0000, d);
			end
		end
		check_frame(16'h0000);

		// ------------------------------------------------------------
		// readback, then writes that must be ignored
		// ------------------------------------------------------------
		for (int v = 0; v < `SYNTH_NUM_VOICES; v++) begin
			write_reg(8'(v << 2), 16'ha5c3 + 16'(v));
			read_reg(8'(v << 2), d);
			check_val("rdata freq", 16'ha5c3 + 16'(v), d);
			write_reg(8'(v << 2), 16'h0000);
		end
		write_reg(8'h10, 16'h1111);
		write_reg(8'h11, 16'h2222);
		write_reg(8'h02, 16'h3333);
		write_reg(8'h03, 16'h4444);
		read_reg(8'h10, d);
		check_val("rdata voice 4 freq", 16'h0000, d);
		read_reg(8'h11, d);
		check_val("rdata voice 4 ampl", 16'h0000, d);
		read_reg(8'h02, d);
		check_val("rdata offset 2", 16'h0000, d);
		read_reg(8'h03, d);
		check_val("rdata offset 3", 16'h0000, d);
		check_frame(16'h0000);

		// mclk follows CLK in both phases.
		@(posedge CLK);
		#10;
		check_val("mclk", 16'h0001, 16'(mclk));
		@(negedge CLK);
		#10;
		check_val("mclk", 16'h0000, 16'(mclk));

		measure_half(0, n);
		if (n != 4) begin
			errors++;
			$display("sclk half period is %0d CLK cycles instead of 4", n);
		end
		measure_half(1, n);
		if (n != 256) begin
			errors++;
			$display("lrclk half period is %0d CLK cycles instead of 256", n);
		end

		// ------------------------------------------------------------
		// table of mixes
		// ------------------------------------------------------------
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (tbl_rand[i])
				tbl_ampl[i] = 16'($random(seed));
			ampl_model[tbl_voice[i]] = tbl_ampl[i];
			if (tbl_rand[i])
				tbl_exp[i] = saturate_sum();
			write_reg(8'(tbl_voice[i] << 2), 16'h0000);
			write_reg(8'((tbl_voice[i] << 2) | 1), tbl_ampl[i]);
			read_reg(8'((tbl_voice[i] << 2) | 1), d);
			check_val("rdata ampl", tbl_ampl[i], d);
			repeat (2) @(negedge lrclk);
			check_frame(tbl_exp[i]);
		end

		// square wave on voice 0, the rest silent.
		for (int v = 1; v < `SYNTH_NUM_VOICES; v++)
			write_reg(8'((v << 2) | 1), 16'h0000);
		write_reg(8'h00, 16'hc0c1);
		write_reg(8'h01, 16'h1234);
		@(negedge lrclk);
		saw_pos = 1'b0;
		saw_neg = 1'b0;
		for (int f = 0; f < 6; f++) begin
			capture_frame(left, right);
			for (int s = 0; s < 2; s++) begin
				last_mix = s ? right : left;
				if (last_mix == 16'h1234)
					saw_pos = 1'b1;
				else if (last_mix == 16'hedcc)
					saw_neg = 1'b1;
				else
					check_val("sdata square", 16'h1234, last_mix);
			end
		end
		if (!saw_pos || !saw_neg) begin
			errors++;
			$display("square wave did not show both polarities");
		end

		$display("closing with %0d errors", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/synth_pkg.sv
logic/voice_regs.sv
voice/square_voice.sv
logic/voice_mixer.sv
i2s/i2s_clock_gen.sv
i2s/i2s_serializer.sv
logic/audio_synth_top.sv
sim/tb_audio_synth.sv

/* Makefile */
# Verilator build and run for the audio synth testbench.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_audio_synth
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FLIST)) common/synth_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
